// File: design/watch_pkg.sv
`default_nettype none

package watch_pkg;

   ////////////////////
   // Counting limits

   localparam int SEC_PER_MIN   = 60;
   localparam int MIN_PER_HR    = 60;
   localparam int HR_PER_DAY    = 24;
   localparam int TICKS_PER_SEC = 1000;  // i_clk cycles per second

   ////////////////////
   // Value widths

   typedef logic [5:0] unit60_t;  // Seconds or minutes
   typedef logic [4:0] hour_t;    // 0 to 23
   typedef logic [9:0] tick_t;    // Prescaler count

   ////////////////////
   // Grouped signals

   // Displayed or counted time, hr in the top bits
   typedef struct packed {
      hour_t   hr;
      unit60_t min;
      unit60_t sec;
   } time_t;

   // Synchronized single-cycle button pulses
   typedef struct packed {
      logic set;
      logic up;
      logic down;
      logic left;
      logic right;
   } buttons_t;

   ////////////////////
   // State machines

   typedef enum logic {
      MODE_CLOCK     = 1'b0,
      MODE_STOPWATCH = 1'b1
   } mode_e;

   // Clock run state and the field being edited
   typedef enum logic [1:0] {
      CLK_RUN     = 2'b00,
      CLK_SET_SEC = 2'b01,
      CLK_SET_MIN = 2'b10,
      CLK_SET_HR  = 2'b11
   } clk_state_e;

endpackage

`default_nettype wire

// File: design/wrap_counter.sv
`timescale 1ns/1ns
`default_nettype none

// Modulo counter shared by prescalers and time fields
module wrap_counter #(
   parameter int MODULUS = 60
) (
   input  logic                         i_clk,
   input  logic                         i_rstn,
   input  logic                         i_up,
   input  logic                         i_down,
   output logic [$clog2(MODULUS)-1:0]   o_count,
   output logic                         o_carry
);

   localparam int W = $clog2(MODULUS);
   localparam logic [W-1:0] LAST = W'(MODULUS - 1);

   logic [W-1:0] r_count;
   logic [W-1:0] w_next_up;
   logic [W-1:0] w_next_down;

   // Wrap in both directions
   assign w_next_up   = (r_count == LAST) ? '0 : r_count + 1'b1;
   assign w_next_down = (r_count == '0) ? LAST : r_count - 1'b1;

   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         r_count <= '0;
      end else begin
         case ({i_up, i_down})
            2'b10:   r_count <= w_next_up;
            2'b01:   r_count <= w_next_down;
            2'b11:   r_count <= '0;  // Both together clear
            default: r_count <= r_count;
         endcase
      end
   end

   assign o_count = r_count;

   // Next stage steps on the same edge as the wrap
   assign o_carry = i_up & ~i_down & (r_count == LAST);

endmodule

`default_nettype wire

// File: design/time_of_day.sv
`timescale 1ns/1ns
`default_nettype none

module time_of_day
   import watch_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rstn,
   input  buttons_t   i_btn,
   output time_t      o_time,
   output clk_state_e o_state
);

   clk_state_e r_state;

   logic    w_run;
   logic    w_edit_sec;
   logic    w_edit_min;
   logic    w_edit_hr;
   logic    w_right;
   logic    w_left;

   logic    w_tick_carry;
   logic    w_sec_carry;
   logic    w_min_carry;
   logic    w_sec_up;
   logic    w_sec_down;
   logic    w_min_up;
   logic    w_min_down;
   logic    w_hr_up;
   logic    w_hr_down;

   unit60_t w_sec;
   unit60_t w_min;
   hour_t   w_hr;

   ////////////////////
   // Run / set FSM

   assign w_right = i_btn.right & ~i_btn.left;  // Both at once is ignored
   assign w_left  = i_btn.left & ~i_btn.right;

   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         r_state <= CLK_RUN;
      end else if (i_btn.set) begin
         r_state <= (r_state == CLK_RUN) ? CLK_SET_SEC : CLK_RUN;
      end else if (w_right) begin
         case (r_state)
            CLK_SET_SEC: r_state <= CLK_SET_HR;
            CLK_SET_HR:  r_state <= CLK_SET_MIN;
            CLK_SET_MIN: r_state <= CLK_SET_SEC;
            default:     r_state <= CLK_RUN;
         endcase
      end else if (w_left) begin
         case (r_state)
            CLK_SET_SEC: r_state <= CLK_SET_MIN;
            CLK_SET_MIN: r_state <= CLK_SET_HR;
            CLK_SET_HR:  r_state <= CLK_SET_SEC;
            default:     r_state <= CLK_RUN;
         endcase
      end
   end

   assign w_run      = (r_state == CLK_RUN);
   assign w_edit_sec = (r_state == CLK_SET_SEC);
   assign w_edit_min = (r_state == CLK_SET_MIN);
   assign w_edit_hr  = (r_state == CLK_SET_HR);

   ////////////////////
   // Counter chain

   // Carries only ripple while running, edits never carry
   assign w_sec_up   = w_run ? w_tick_carry : (w_edit_sec & i_btn.up);
   assign w_sec_down = w_edit_sec & i_btn.down;
   assign w_min_up   = w_run ? w_sec_carry : (w_edit_min & i_btn.up);
   assign w_min_down = w_edit_min & i_btn.down;
   assign w_hr_up    = w_run ? w_min_carry : (w_edit_hr & i_btn.up);
   assign w_hr_down  = w_edit_hr & i_btn.down;

   // Up and down together hold the prescaler at zero while editing
   wrap_counter #(.MODULUS(TICKS_PER_SEC)) u_tick (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_up(1'b1), .i_down(~w_run),
      .o_count(), .o_carry(w_tick_carry)
   );

   wrap_counter #(.MODULUS(SEC_PER_MIN)) u_sec (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_up(w_sec_up), .i_down(w_sec_down),
      .o_count(w_sec), .o_carry(w_sec_carry)
   );

   wrap_counter #(.MODULUS(MIN_PER_HR)) u_min (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_up(w_min_up), .i_down(w_min_down),
      .o_count(w_min), .o_carry(w_min_carry)
   );

   wrap_counter #(.MODULUS(HR_PER_DAY)) u_hr (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_up(w_hr_up), .i_down(w_hr_down),
      .o_count(w_hr), .o_carry()  // Day rollover goes nowhere
   );

   assign o_time  = '{hr: w_hr, min: w_min, sec: w_sec};
   assign o_state = r_state;

endmodule

`default_nettype wire

// File: design/stopwatch.sv
`timescale 1ns/1ns
`default_nettype none

module stopwatch
   import watch_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_rstn,
   input  buttons_t i_btn,
   output time_t    o_time
);

   logic    r_run;
   logic    w_any_arrow;

   logic    w_tick_up;
   logic    w_tick_carry;
   logic    w_sec_up;
   logic    w_sec_carry;
   logic    w_min_up;
   logic    w_min_carry;
   logic    w_hr_up;

   unit60_t w_sec;
   unit60_t w_min;
   hour_t   w_hr;

   ////////////////////
   // Start / stop

   assign w_any_arrow = i_btn.up | i_btn.down | i_btn.left | i_btn.right;

   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         r_run <= 1'b0;
      end else if (i_btn.set) begin
         r_run <= 1'b0;  // Clear always stops
      end else if (w_any_arrow) begin
         r_run <= ~r_run;
      end
   end

   ////////////////////
   // Elapsed time chain

   // Set drives up and down together, which clears every stage
   assign w_tick_up = r_run | i_btn.set;
   assign w_sec_up  = (r_run & w_tick_carry) | i_btn.set;
   assign w_min_up  = (r_run & w_sec_carry) | i_btn.set;
   assign w_hr_up   = (r_run & w_min_carry) | i_btn.set;

   wrap_counter #(.MODULUS(TICKS_PER_SEC)) u_tick (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_up(w_tick_up), .i_down(i_btn.set),
      .o_count(), .o_carry(w_tick_carry)
   );

   wrap_counter #(.MODULUS(SEC_PER_MIN)) u_sec (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_up(w_sec_up), .i_down(i_btn.set),
      .o_count(w_sec), .o_carry(w_sec_carry)
   );

   wrap_counter #(.MODULUS(MIN_PER_HR)) u_min (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_up(w_min_up), .i_down(i_btn.set),
      .o_count(w_min), .o_carry(w_min_carry)
   );

   // Wraps after a full day
   wrap_counter #(.MODULUS(HR_PER_DAY)) u_hr (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_up(w_hr_up), .i_down(i_btn.set),
      .o_count(w_hr), .o_carry()
   );

   assign o_time = '{hr: w_hr, min: w_min, sec: w_sec};

endmodule

`default_nettype wire

// File: design/watch_core.sv
`timescale 1ns/1ns
`default_nettype none

module watch_core
   import watch_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_rstn,
   input  logic     i_mode,
   input  buttons_t i_btn,
   input  time_t    i_clk_time,
   input  time_t    i_sw_time,
   output buttons_t o_clk_btn,
   output buttons_t o_sw_btn,
   output time_t    o_disp,
   output mode_e    o_mode
);

   mode_e r_mode;
   logic  w_clock_active;

   ////////////////////
   // Mode register

   // Clock and stopwatch alternate on each mode pulse
   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         r_mode <= MODE_CLOCK;
      end else if (i_mode) begin
         r_mode <= (r_mode == MODE_CLOCK) ? MODE_STOPWATCH : MODE_CLOCK;
      end
   end

   assign w_clock_active = (r_mode == MODE_CLOCK);

   ////////////////////
   // Button routing

   // Uses the current mode, so a button with i_mode goes to the old mode
   assign o_clk_btn = w_clock_active ? i_btn : '0;
   assign o_sw_btn  = w_clock_active ? '0 : i_btn;

   // Display follows the active mode
   assign o_disp = w_clock_active ? i_clk_time : i_sw_time;
   assign o_mode = r_mode;

endmodule

`default_nettype wire

// File: design/watch_top.sv
`timescale 1ns/1ns
`default_nettype none

module watch_top
   import watch_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_rstn,
   input  logic       i_mode,
   input  buttons_t   i_btn,
   output time_t      o_disp,
   output mode_e      o_mode,
   output clk_state_e o_clk_state
);

   buttons_t w_clk_btn;
   buttons_t w_sw_btn;
   time_t    w_clk_time;
   time_t    w_sw_time;

   watch_core u_core (
      .i_clk      (i_clk),
      .i_rstn     (i_rstn),
      .i_mode     (i_mode),
      .i_btn      (i_btn),
      .i_clk_time (w_clk_time),
      .i_sw_time  (w_sw_time),
      .o_clk_btn  (w_clk_btn),
      .o_sw_btn   (w_sw_btn),
      .o_disp     (o_disp),
      .o_mode     (o_mode)
   );

   // Both modes keep counting whichever one is shown
   time_of_day u_clock (
      .i_clk   (i_clk),
      .i_rstn  (i_rstn),
      .i_btn   (w_clk_btn),
      .o_time  (w_clk_time),
      .o_state (o_clk_state)  // Edit field for the display
   );

   stopwatch u_stopwatch (
      .i_clk  (i_clk),
      .i_rstn (i_rstn),
      .i_btn  (w_sw_btn),
      .o_time (w_sw_time)
   );

endmodule

`default_nettype wire

// File: bench/watch_props.sv
`timescale 1ns/1ns
`default_nettype none

module watch_props
   import watch_pkg::*;
(
   input logic       i_clk,
   input logic       i_rstn,
   input logic       i_mode,
   input buttons_t   i_btn,
   input time_t      o_disp,
   input mode_e      o_mode,
   input clk_state_e o_clk_state
);

   logic w_clock_set;

   assign w_clock_set = i_btn.set & (o_mode == MODE_CLOCK);  // Set only reaches the clock here

   a_disp_range: assert property (@(posedge i_clk) disable iff (!i_rstn)
      o_disp.sec < SEC_PER_MIN && o_disp.min < MIN_PER_HR && o_disp.hr < HR_PER_DAY)
      else $error("display field out of range");

   a_mode_stable: assert property (@(posedge i_clk) disable iff (!i_rstn)
      !i_mode |=> $stable(o_mode))
      else $error("mode changed without a mode pulse");

   // Run state is left only through a set pulse
   a_run_held: assert property (@(posedge i_clk) disable iff (!i_rstn)
      (o_clk_state == CLK_RUN) && !w_clock_set |=> o_clk_state == CLK_RUN)
      else $error("clock left run state without a set pulse");

endmodule

bind watch_top watch_props u_props (.*);

`default_nettype wire

// File: bench/watch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module watch_tb
   import watch_pkg::*;
();

   localparam int TEST_CYCLES = 10 * TICKS_PER_SEC;  // About 7 s of waits plus pulses
   localparam int DAY_SECS    = HR_PER_DAY * MIN_PER_HR * SEC_PER_MIN;
   localparam int HOUR_SECS   = MIN_PER_HR * SEC_PER_MIN;

   // Field order is set, up, down, left, right
   localparam buttons_t BTN_SET   = 5'b10000;
   localparam buttons_t BTN_UP    = 5'b01000;
   localparam buttons_t BTN_DOWN  = 5'b00100;
   localparam buttons_t BTN_LEFT  = 5'b00010;
   localparam buttons_t BTN_RIGHT = 5'b00001;
   localparam buttons_t BTN_CLEAR = 5'b01100;  // Up and down together

   logic       i_clk;
   logic       i_rstn;
   logic       i_mode;
   buttons_t   i_btn;
   time_t      o_disp;
   mode_e      o_mode;
   clk_state_e o_clk_state;

   int         cycle_cnt = 0;
   int         check_cnt = 0;
   int         err_cnt = 0;
   int         test_cnt = 0;
   int         fail_tests = 0;
   int         test_err_base;
   int         run_start;  // Cycle count when the clock last left set mode
   int         base_secs;  // Clock time at that point
   logic [7:0] lfsr;

   watch_top i_watch_top (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_mode(i_mode), .i_btn(i_btn),
      .o_disp(o_disp), .o_mode(o_mode), .o_clk_state(o_clk_state)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      wait (cycle_cnt >= 2 * TEST_CYCLES);
      $display("Timeout: the tests did not finish within %0d clock cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
   end

   ////////////////////
   // Helpers

   // Taps 8 6 5 4
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   function automatic int take_bits(input int n);
      int v;
      v = 0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         v = (v << 1) | int'(lfsr[0]);
      end
      return v;
   endfunction

   function automatic time_t from_secs(input int s);
      time_t t;
      t.sec = unit60_t'(s % SEC_PER_MIN);
      t.min = unit60_t'(s / SEC_PER_MIN % MIN_PER_HR);
      t.hr  = hour_t'(s / HOUR_SECS % HR_PER_DAY);  // Day wraps to zero
      return t;
   endfunction

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_time(input string what, input time_t exp);
      check_eq({what, " hours"}, o_disp.hr, exp.hr);
      check_eq({what, " minutes"}, o_disp.min, exp.min);
      check_eq({what, " seconds"}, o_disp.sec, exp.sec);
   endtask

   // Whole seconds counted since the clock left set mode
   task automatic check_clock(input string what);
      check_time(what, from_secs(base_secs + (cycle_cnt - run_start) / TICKS_PER_SEC));
   endtask

   // One-cycle strobe taken by the DUT at the edge that ends it
   task automatic pulse(input buttons_t b, input logic m);
      @(posedge i_clk);
      i_btn  <= b;
      i_mode <= m;
      @(posedge i_clk);
      i_btn  <= '0;
      i_mode <= 1'b0;
   endtask

   task automatic start_test();
      test_cnt++;
      test_err_base = err_cnt;
   endtask

   task automatic end_test(input string name);
      if (err_cnt == test_err_base) begin
         $display("Test %0d, %s: ok", test_cnt, name);
      end else begin
         fail_tests++;
         $display("Test %0d, %s: %0d mismatches", test_cnt, name, err_cnt - test_err_base);
      end
   endtask

   ////////////////////
   // Tests

   task automatic test_reset_values();
      start_test();
      @(negedge i_clk);
      check_eq("mode", o_mode, MODE_CLOCK);
      check_eq("clock state", o_clk_state, CLK_RUN);
      check_time("display", '0);
      end_test("reset values");
   endtask

   task automatic test_set_clock();
      int n_sec;
      int n_hr;
      int exp_secs;
      start_test();
      // Nonzero fields so that a later clear is visible
      n_sec = 1 + take_bits(6) % (SEC_PER_MIN - 1);
      n_hr  = 1 + take_bits(5) % (HR_PER_DAY - 1);
      pulse(BTN_SET, 1'b0);
      @(negedge i_clk);
      check_eq("clock state", o_clk_state, CLK_SET_SEC);
      repeat (n_sec) pulse(BTN_UP, 1'b0);
      @(negedge i_clk);
      check_time("seconds set", from_secs(n_sec % SEC_PER_MIN));
      pulse(BTN_RIGHT, 1'b0);  // sec to hr
      repeat (n_hr) pulse(BTN_UP, 1'b0);
      @(negedge i_clk);
      check_eq("clock state", o_clk_state, CLK_SET_HR);
      exp_secs = (n_hr % HR_PER_DAY) * HOUR_SECS + n_sec % SEC_PER_MIN;
      check_time("hours set", from_secs(exp_secs));
      pulse(BTN_CLEAR, 1'b0);
      pulse(BTN_DOWN, 1'b0);
      @(negedge i_clk);
      exp_secs = (HR_PER_DAY - 1) * HOUR_SECS + n_sec % SEC_PER_MIN;
      check_time("hour wrap below zero", from_secs(exp_secs));
      pulse(BTN_RIGHT, 1'b0);
      @(negedge i_clk);
      check_eq("clock state", o_clk_state, CLK_SET_MIN);
      pulse(BTN_RIGHT, 1'b0);  // Back round to seconds
      pulse(BTN_CLEAR, 1'b0);
      @(negedge i_clk);
      check_eq("clock state", o_clk_state, CLK_SET_SEC);
      check_time("seconds cleared", from_secs((HR_PER_DAY - 1) * HOUR_SECS));
      pulse(BTN_SET, 1'b0);
      @(negedge i_clk);
      check_eq("clock state", o_clk_state, CLK_RUN);
      end_test("setting the clock");
   endtask

   task automatic test_carry();
      clk_state_e exp_field[3] = '{CLK_SET_MIN, CLK_SET_HR, CLK_SET_SEC};
      start_test();
      pulse(BTN_SET, 1'b0);
      // Clear and step down each field in turn
      for (int f = 0; f < 3; f++) begin
         pulse(BTN_CLEAR, 1'b0);
         pulse(BTN_DOWN, 1'b0);
         pulse(BTN_LEFT, 1'b0);
         @(negedge i_clk);
         check_eq("clock state after left", o_clk_state, exp_field[f]);
      end
      base_secs = DAY_SECS - 1;
      check_time("last second of day", from_secs(base_secs));
      pulse(BTN_SET, 1'b0);
      @(negedge i_clk);
      run_start = cycle_cnt;
      repeat (TICKS_PER_SEC - 1) @(posedge i_clk);
      @(negedge i_clk);
      check_time("one edge before rollover", from_secs(base_secs));
      @(negedge i_clk);
      check_time("rollover", '0);
      end_test("timekeeping carry");
   endtask

   task automatic test_stopwatch();
      start_test();
      pulse('0, 1'b1);
      @(negedge i_clk);
      check_eq("mode", o_mode, MODE_STOPWATCH);
      check_time("stopwatch at start", '0);
      pulse(BTN_UP, 1'b0);
      repeat (3 * TICKS_PER_SEC - 1) @(posedge i_clk);
      @(negedge i_clk);
      check_time("stopwatch before third second", from_secs(2));
      pulse(BTN_LEFT, 1'b0);
      @(negedge i_clk);
      check_time("stopwatch stopped", from_secs(3));
      repeat (2 * TICKS_PER_SEC) @(posedge i_clk);
      @(negedge i_clk);
      check_time("stopwatch held", from_secs(3));
      pulse(BTN_SET, 1'b0);
      @(negedge i_clk);
      check_time("stopwatch cleared", '0);
      end_test("stopwatch");
   endtask

   task automatic test_mode_isolation();
      start_test();
      pulse('0, 1'b1);
      @(negedge i_clk);
      check_eq("mode", o_mode, MODE_CLOCK);
      check_clock("clock after stopwatch");
      pulse(BTN_UP, 1'b0);
      pulse(BTN_DOWN, 1'b0);
      pulse(BTN_LEFT, 1'b0);
      pulse(BTN_RIGHT, 1'b0);
      @(negedge i_clk);
      check_eq("clock state", o_clk_state, CLK_RUN);
      pulse('0, 1'b1);
      repeat (TICKS_PER_SEC) @(posedge i_clk);
      @(negedge i_clk);
      check_time("stopwatch untouched", '0);
      pulse('0, 1'b1);
      @(negedge i_clk);
      check_clock("clock after second visit");
      end_test("mode isolation");
   endtask

   initial begin
      lfsr   = 8'd56;
      i_rstn = 1'b0;
      i_mode = 1'b0;
      i_btn  = '0;
      repeat (8) @(posedge i_clk);
      i_rstn <= 1'b1;
      test_reset_values();
      test_set_clock();
      test_carry();
      test_stopwatch();
      test_mode_isolation();
      $display("Done: %0d of %0d tests failed, %0d of %0d checks mismatched",
               fail_tests, test_cnt, err_cnt, check_cnt);
      if (err_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
design/watch_pkg.sv
design/wrap_counter.sv
design/time_of_day.sv
design/stopwatch.sv
design/watch_core.sv
design/watch_top.sv
bench/watch_props.sv
bench/watch_tb.sv

// File: Bender.yml
package:
  name: watch

sources:
  # Package first, then leaf modules up to the top level
  - files:
      - design/watch_pkg.sv
      - design/wrap_counter.sv
      - design/time_of_day.sv
      - design/stopwatch.sv
      - design/watch_core.sv
      - design/watch_top.sv
  - target: test
    files:
      - bench/watch_props.sv
      - bench/watch_tb.sv
